// ==== bary_params.svh ====
`ifndef BARY_PARAMS_SVH
`define BARY_PARAMS_SVH

// Input coordinates, signed integers
`define BARY_COORD_W 16

// Q16.16 results
`define BARY_FRAC_W 16
`define BARY_RES_W 32

// A.x A.y B.x B.y C.x C.y P.x P.y
`define BARY_IN_WORDS 8

// Two 17x17 products summed
`define BARY_EDGE_W 35

// Dividend magnitude plus fraction bits
`define BARY_DIV_STEPS 51

`endif

// ==== bary_pkg.sv ====
`include "bary_params.svh"

package bary_pkg;

    typedef logic signed [`BARY_COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // One extra bit so a coordinate difference never overflows
    typedef logic signed [`BARY_COORD_W:0] diff_t;

    // Denominator and both numerators
    typedef logic signed [`BARY_EDGE_W-1:0] edge_t;

    // Q16.16 barycentric weight
    typedef logic signed [`BARY_RES_W-1:0] bary_t;

    localparam bary_t bary_one = bary_t'(1 << `BARY_FRAC_W);  // 1.0

endpackage

// ==== bary_if.sv ====
`timescale 1ns/1ns

// One triangle job, A/B/C plus the query point
interface tri_if;
    import bary_pkg::*;

    logic   valid;
    logic   ready;
    point_t a;
    point_t b;
    point_t c;
    point_t p;

    modport src (
        output valid,
        output a,
        output b,
        output c,
        output p,
        input  ready
    );

    modport dst (
        input  valid,
        input  a,
        input  b,
        input  c,
        input  p,
        output ready
    );

endinterface

// Solved weights for one job
interface bary_if;
    import bary_pkg::*;

    logic  valid;
    logic  ready;
    bary_t u;
    bary_t v;
    bary_t w;

    modport src (
        output valid,
        output u,
        output v,
        output w,
        input  ready
    );

    modport dst (
        input  valid,
        input  u,
        input  v,
        input  w,
        output ready
    );

endinterface

// ==== vertex_loader.sv ====
`timescale 1ns/1ns
`include "bary_params.svh"

module vertex_loader (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  bary_pkg::coord_t in_data,
    output logic             in_ready,
    tri_if.src               tri_out
);
    import bary_pkg::*;

    localparam int CNT_W = $clog2(`BARY_IN_WORDS);

    logic [CNT_W-1:0] word_cnt;
    logic             job_valid;
    logic             word_take;
    point_t           pts [4];    // A, B, C, P

    // Stall input while a full job is waiting downstream
    assign in_ready  = !job_valid;
    assign word_take = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt  <= '0;
            job_valid <= 1'b0;
        end else begin
            if (word_take) begin
                if (word_cnt == CNT_W'(`BARY_IN_WORDS - 1)) begin
                    word_cnt  <= '0;
                    job_valid <= 1'b1;    // Eighth word completes the job
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end

            if (job_valid && tri_out.ready) begin
                job_valid <= 1'b0;
            end
        end
    end

    // Upper counter bits pick the point, LSB picks x or y
    always_ff @(posedge clk) begin
        if (word_take) begin
            if (word_cnt[0]) begin
                pts[word_cnt[CNT_W-1:1]].y <= in_data;
            end else begin
                pts[word_cnt[CNT_W-1:1]].x <= in_data;
            end
        end
    end

    assign tri_out.valid = job_valid;
    assign tri_out.a     = pts[0];
    assign tri_out.b     = pts[1];
    assign tri_out.c     = pts[2];
    assign tri_out.p     = pts[3];

endmodule

// ==== edge_function_unit.sv ====
`timescale 1ns/1ns

module edge_function_unit (
    input  logic            clk,
    input  logic            rst_n,
    tri_if.dst              tri_in,
    output logic            edge_valid,
    output bary_pkg::edge_t denom,
    output bary_pkg::edge_t num_u,
    output bary_pkg::edge_t num_v,
    input  logic            edge_ready
);
    import bary_pkg::*;

    logic  s1_valid;
    logic  adv1;
    logic  adv2;
    diff_t d_byc, d_axc, d_cxb, d_ayc;    // Shared by denominator and numerators
    diff_t d_cya, d_pxc, d_pyc;

    function automatic diff_t diff(input coord_t lhs, input coord_t rhs);
        return diff_t'(lhs) - diff_t'(rhs);
    endfunction

    // Sum of two signed products at full edge width
    function automatic edge_t cross2(input diff_t a0, input diff_t b0,
                                     input diff_t a1, input diff_t b1);
        return edge_t'(a0) * edge_t'(b0) + edge_t'(a1) * edge_t'(b1);
    endfunction

    // Each stage moves when the one after it has room
    assign adv2         = !edge_valid || edge_ready;
    assign adv1         = !s1_valid || adv2;
    assign tri_in.ready = adv1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid   <= 1'b0;
            edge_valid <= 1'b0;
        end else begin
            if (adv1) s1_valid <= tri_in.valid;
            if (adv2) edge_valid <= s1_valid;
        end
    end

    // Stage one, the seven differences
    always_ff @(posedge clk) begin
        if (adv1 && tri_in.valid) begin
            d_byc <= diff(tri_in.b.y, tri_in.c.y);
            d_axc <= diff(tri_in.a.x, tri_in.c.x);
            d_cxb <= diff(tri_in.c.x, tri_in.b.x);
            d_ayc <= diff(tri_in.a.y, tri_in.c.y);
            d_cya <= diff(tri_in.c.y, tri_in.a.y);
            d_pxc <= diff(tri_in.p.x, tri_in.c.x);
            d_pyc <= diff(tri_in.p.y, tri_in.c.y);
        end
    end

    // Stage two, products and sums
    always_ff @(posedge clk) begin
        if (adv2 && s1_valid) begin
            denom <= cross2(d_byc, d_axc, d_cxb, d_ayc);
            num_u <= cross2(d_byc, d_pxc, d_cxb, d_pyc);
            num_v <= cross2(d_cya, d_pxc, d_axc, d_pyc);
        end
    end

endmodule

// ==== fixed_divider.sv ====
`timescale 1ns/1ns
`include "bary_params.svh"

module fixed_divider (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  bary_pkg::edge_t dividend,
    input  bary_pkg::edge_t divisor,
    output logic            busy,
    output logic            done,
    output bary_pkg::bary_t quotient
);
    import bary_pkg::*;

    localparam int EW    = `BARY_EDGE_W;
    localparam int RW    = `BARY_RES_W;
    localparam int STEPS = `BARY_DIV_STEPS;
    localparam int CW    = $clog2(STEPS);

    logic [CW-1:0]    step;
    logic             last_step;
    logic             load;
    logic [EW-1:0]    dvd_mag;
    logic [EW-1:0]    dvs_mag;
    logic [EW-1:0]    dmag;       // Divisor magnitude for this run
    logic [EW-1:0]    rem;
    logic [STEPS-1:0] quo;        // Dividend bits shift out, quotient bits shift in
    logic             neg;
    logic [EW:0]      rem_sh;
    logic [EW:0]      trial;
    logic             q_bit;
    logic [EW-1:0]    rem_nx;
    logic [STEPS-1:0] quo_nx;
    logic [RW-1:0]    q_low;

    assign load      = start && !busy;
    assign last_step = (step == CW'(STEPS - 1));

    assign dvd_mag = dividend[EW-1] ? -dividend : dividend;
    assign dvs_mag = divisor[EW-1] ? -divisor : divisor;

    // One restoring step
    always_comb begin
        rem_sh = {rem, quo[STEPS-1]};
        trial  = rem_sh - {1'b0, dmag};
        q_bit  = !trial[EW];          // No borrow, so the divisor fits
        rem_nx = q_bit ? trial[EW-1:0] : rem_sh[EW-1:0];
        quo_nx = {quo[STEPS-2:0], q_bit};
        q_low  = quo_nx[RW-1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            done <= 1'b0;
            if (load) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                if (last_step) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dmag <= dvs_mag;
            rem  <= '0;
            quo  <= {dvd_mag, {`BARY_FRAC_W{1'b0}}};    // Scale to Q16.16
            neg  <= dividend[EW-1] ^ divisor[EW-1];
        end else if (busy) begin
            rem <= rem_nx;
            quo <= quo_nx;
            if (last_step) begin
                quotient <= neg ? -q_low : q_low;     // Truncates toward zero
            end
        end
    end

endmodule

// ==== bary_solver.sv ====
`timescale 1ns/1ns

module bary_solver (
    input logic clk,
    input logic rst_n,
    tri_if.dst  tri_in,
    bary_if.src res_out
);
    import bary_pkg::*;

    logic  edge_valid;
    logic  edge_ready;
    logic  edge_take;
    logic  degenerate;
    edge_t denom;
    edge_t num_u;
    edge_t num_v;
    logic  div_start;
    logic  busy_u, busy_v;
    logic  done_u, done_v;
    bary_t quo_u, quo_v;
    logic  res_valid;
    bary_t u_q, v_q, w_q;

    edge_function_unit i_edge (
        .clk        (clk),
        .rst_n      (rst_n),
        .tri_in     (tri_in),
        .edge_valid (edge_valid),
        .denom      (denom),
        .num_u      (num_u),
        .num_v      (num_v),
        .edge_ready (edge_ready)
    );

    // Take a new job only with both dividers idle and nothing waiting
    assign edge_ready = !(busy_u || busy_v || done_u || done_v || res_valid);
    assign edge_take  = edge_valid && edge_ready;
    assign degenerate = (denom == '0);     // Collinear or repeated vertices
    assign div_start  = edge_take && !degenerate;

    fixed_divider i_div_u (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (div_start),
        .dividend (num_u),
        .divisor  (denom),
        .busy     (busy_u),
        .done     (done_u),
        .quotient (quo_u)
    );

    fixed_divider i_div_v (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (div_start),
        .dividend (num_v),
        .divisor  (denom),
        .busy     (busy_v),
        .done     (done_v),
        .quotient (quo_v)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (edge_take && degenerate) begin
            res_valid <= 1'b1;
        end else if (done_u && done_v) begin
            res_valid <= 1'b1;
        end else if (res_valid && res_out.ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (edge_take && degenerate) begin
            u_q <= '0;
            v_q <= '0;
            w_q <= bary_one;
        end else if (done_u && done_v) begin
            u_q <= quo_u;
            v_q <= quo_v;
            w_q <= bary_one - quo_u - quo_v;    // Wraps like the quotients
        end
    end

    assign res_out.valid = res_valid;
    assign res_out.u     = u_q;
    assign res_out.v     = v_q;
    assign res_out.w     = w_q;

endmodule

// ==== coord_serializer.sv ====
`timescale 1ns/1ns

module coord_serializer (
    input  logic            clk,
    input  logic            rst_n,
    bary_if.dst             res_in,
    output logic            out_valid,
    output bary_pkg::bary_t out_data,
    output logic            out_last,
    input  logic            out_ready
);
    import bary_pkg::*;

    logic       active;
    logic [1:0] beat;       // 0 u, 1 v, 2 w
    bary_t      u_q, v_q, w_q;

    assign res_in.ready = !active;
    assign out_valid    = active;
    assign out_last     = active && (beat == 2'd2);

    always_comb begin
        case (beat)
            2'd0:    out_data = u_q;
            2'd1:    out_data = v_q;
            default: out_data = w_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            beat   <= 2'd0;
        end else if (!active) begin
            if (res_in.valid) begin
                active <= 1'b1;
                beat   <= 2'd0;
            end
        end else if (out_ready) begin
            if (beat == 2'd2) active <= 1'b0;   // Job done after w
            else beat <= beat + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (res_in.valid && res_in.ready) begin
            u_q <= res_in.u;
            v_q <= res_in.v;
            w_q <= res_in.w;
        end
    end

endmodule

// ==== barycentric.sv ====
`timescale 1ns/1ns

module barycentric (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  bary_pkg::coord_t in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output bary_pkg::bary_t  out_data,
    output logic             out_last
);

    tri_if  tri_bus ();     // Loader to solver
    bary_if res_bus ();     // Solver to serializer

    vertex_loader i_loader (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_ready (in_ready),
        .tri_out  (tri_bus)
    );

    bary_solver i_solver (
        .clk     (clk),
        .rst_n   (rst_n),
        .tri_in  (tri_bus),
        .res_out (res_bus)
    );

    coord_serializer i_serializer (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_in    (res_bus),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

endmodule

// ==== tb_barycentric.sv ====
`timescale 1ns/1ns
`include "bary_params.svh"

module tb_barycentric;
    import bary_pkg::*;

    localparam logic [31:0] SEED = 32'h121d91f0;
    localparam int JOBS_TOTAL = 54;
    localparam int LIMIT_NS   = JOBS_TOTAL * (`BARY_DIV_STEPS + 40) * 4 * 20;

    localparam int KIND_INSIDE = 0;
    localparam int KIND_RANDOM = 1;
    localparam int KIND_DEGEN  = 2;
    localparam int KIND_MIXED  = 3;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    logic   in_ready;
    coord_t in_data;
    logic   out_valid;
    logic   out_ready;
    bary_t  out_data;
    logic   out_last;

    logic [31:0] rng_in;
    logic [31:0] rng_out;     // Separate stream for the output side
    int          gap_pct;
    int          stall_pct;
    int          errors;
    int          checks;
    int          tests;
    bary_t       exp_data [$];
    logic        exp_last [$];

    barycentric i_barycentric (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_in();
        rng_in = xorshift32(rng_in);
        return rng_in;
    endfunction

    function automatic logic [31:0] next_out();
        rng_out = xorshift32(rng_out);
        return rng_out;
    endfunction

    // Range -1000..1000
    function automatic coord_t small_coord();
        return coord_t'(int'(next_in() % 32'd2001) - 1000);
    endfunction

    task automatic check_bary(input string name, input bary_t got, input bary_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Expected words for one job, straight from the edge equations
    task automatic push_job(input point_t a, input point_t b, input point_t c, input point_t p);
        longint den;
        longint nu;
        longint nv;
        bary_t  u;
        bary_t  v;
        den = (longint'(b.y) - longint'(c.y)) * (longint'(a.x) - longint'(c.x))
            + (longint'(c.x) - longint'(b.x)) * (longint'(a.y) - longint'(c.y));
        nu  = (longint'(b.y) - longint'(c.y)) * (longint'(p.x) - longint'(c.x))
            + (longint'(c.x) - longint'(b.x)) * (longint'(p.y) - longint'(c.y));
        nv  = (longint'(c.y) - longint'(a.y)) * (longint'(p.x) - longint'(c.x))
            + (longint'(a.x) - longint'(c.x)) * (longint'(p.y) - longint'(c.y));
        if (den == 0) begin
            u = '0;
            v = '0;
        end else begin
            u = bary_t'((nu * 65536) / den);    // Truncates toward zero
            v = bary_t'((nv * 65536) / den);
        end
        exp_data.push_back(u);
        exp_data.push_back(v);
        exp_data.push_back(32'h00010000 - u - v);
        exp_last.push_back(1'b0);
        exp_last.push_back(1'b0);
        exp_last.push_back(1'b1);
    endtask

    // Starts and ends on a falling edge
    task automatic send_word(input coord_t word);
        logic taken;
        while ((next_in() % 32'd100) < 32'(gap_pct)) begin
            in_valid = 1'b0;
            @(negedge clk);
        end
        in_valid = 1'b1;
        in_data  = word;
        do begin
            taken = in_ready;   // Holds until the next rising edge
            @(negedge clk);
        end while (!taken);
    endtask

    task automatic send_job(input point_t a, input point_t b, input point_t c, input point_t p);
        push_job(a, b, c, p);
        send_word(a.x);
        send_word(a.y);
        send_word(b.x);
        send_word(b.y);
        send_word(c.x);
        send_word(c.y);
        send_word(p.x);
        send_word(p.y);
    endtask

    // P as a small weighted mean of the vertices
    task automatic inside_job();
        point_t a, b, c, p;
        int     wa, wb, wc, s;
        a.x = small_coord();
        a.y = small_coord();
        b.x = small_coord();
        b.y = small_coord();
        c.x = small_coord();
        c.y = small_coord();
        wa  = int'(next_in() % 32'd16);
        wb  = int'(next_in() % 32'd16);
        wc  = int'(next_in() % 32'd16);
        s   = wa + wb + wc;
        if (s == 0) begin
            wa = 1;
            s  = 1;
        end
        p.x = coord_t'((wa * int'(a.x) + wb * int'(b.x) + wc * int'(c.x)) / s);
        p.y = coord_t'((wa * int'(a.y) + wb * int'(b.y) + wc * int'(c.y)) / s);
        send_job(a, b, c, p);
    endtask

    task automatic random_job();
        point_t a, b, c, p;
        a = point_t'(next_in());
        b = point_t'(next_in());
        c = point_t'(next_in());
        p = point_t'(next_in());
        send_job(a, b, c, p);
    endtask

    // Even k repeats a vertex, odd k puts C on the line through A and B
    task automatic degenerate_job(input int k);
        point_t a, b, c, p;
        int     dx, dy;
        a.x = small_coord();
        a.y = small_coord();
        p.x = small_coord();
        p.y = small_coord();
        if (k % 2 == 0) begin
            b   = a;
            c.x = small_coord();
            c.y = small_coord();
        end else begin
            dx  = int'(next_in() % 32'd41) - 20;
            dy  = int'(next_in() % 32'd41) - 20;
            b.x = coord_t'(int'(a.x) + dx);
            b.y = coord_t'(int'(a.y) + dy);
            c.x = coord_t'(int'(a.x) + 2 * dx);
            c.y = coord_t'(int'(a.y) + 2 * dy);
        end
        send_job(a, b, c, p);
    endtask

    task automatic run_test(input string name, input int kind, input int jobs,
                            input int gaps, input int stalls);
        int err0;
        err0      = errors;
        gap_pct   = gaps;
        stall_pct = stalls;
        for (int k = 0; k < jobs; k++) begin
            case (kind)
                KIND_INSIDE: inside_job();
                KIND_RANDOM: random_job();
                KIND_DEGEN:  degenerate_job(k);
                default: begin
                    if (k % 3 == 0) degenerate_job(k);
                    else if (k % 3 == 1) inside_job();
                    else random_job();
                end
            endcase
        end
        in_valid = 1'b0;
        while (exp_data.size() != 0) @(negedge clk);   // Drain the DUT
        tests++;
        $display("test %-14s %0d jobs, %0d errors", name, jobs, errors - err0);
    endtask

    // Output side, random out_ready and beat checks
    initial begin
        out_ready = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            out_ready = (next_out() % 32'd100) >= 32'(stall_pct);
            if (out_valid && out_ready) begin
                if (exp_data.size() == 0) begin
                    errors++;
                    $display("output beat arrived with no job pending");
                end else begin
                    check_bary("out_data", out_data, exp_data.pop_front());
                    check_last("out_last", out_last, exp_last.pop_front());
                end
            end
        end
    end

    initial begin
        #(LIMIT_NS);
        $display("timeout: the jobs did not finish within %0d ns", LIMIT_NS);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rng_in    = SEED;
        rng_out   = {SEED[15:0], SEED[31:16]};
        errors    = 0;
        checks    = 0;
        tests     = 0;
        gap_pct   = 0;
        stall_pct = 0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_last("in_ready", in_ready, 1'b1);
        check_last("out_valid", out_valid, 1'b0);
        tests++;
        $display("test %-14s %0d errors", "reset", errors);

        run_test("inside", KIND_INSIDE, 12, 10, 10);
        run_test("random", KIND_RANDOM, 16, 10, 10);
        run_test("degenerate", KIND_DEGEN, 6, 0, 0);
        run_test("stalls", KIND_MIXED, 12, 40, 50);
        run_test("back_to_back", KIND_RANDOM, 8, 0, 0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== barycentric.f ====
+incdir+.
bary_pkg.sv
bary_if.sv
vertex_loader.sv
edge_function_unit.sv
fixed_divider.sv
bary_solver.sv
coord_serializer.sv
barycentric.sv
tb_barycentric.sv

// ==== Makefile ====
RTL = bary_pkg.sv bary_if.sv vertex_loader.sv edge_function_unit.sv fixed_divider.sv \
      bary_solver.sv coord_serializer.sv barycentric.sv

.PHONY: all lint clean

all:
	verilator --binary -f barycentric.f --top-module tb_barycentric -o tb_barycentric
	@out="$$(./obj_dir/tb_barycentric)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

lint:
	verilator --lint-only +incdir+. $(RTL) --top-module barycentric

clean:
	rm -rf obj_dir
